// File: logic/dac_cfg_pkg.sv
`default_nettype none

package dac_cfg_pkg;

    // input sample and coefficient widths
    localparam int SAMPLE_W = 10;
    localparam int COE_W    = 10;

    // matrix limits
    localparam int MAX_COLS = 64;
    localparam int MAX_ROWS = 8;
    localparam int COL_W    = 6;
    localparam int ROW_W    = 3;

    // 64 products of 20 bits each fit without overflow
    localparam int ACC_W    = 26;
    localparam int DIV_W    = 5;

    localparam int DAC_W    = 10;
    localparam int DAC_MAX  = 1023;

    typedef struct packed {
        logic [ROW_W-1:0] row;
        logic [DAC_W-1:0] sample;
    } dac_result_t;

    typedef enum logic [1:0] {
        idle,
        accumulate,
        drain,
        divide_wait
    } engine_state_t;

endpackage

`default_nettype wire

// File: logic/dac_bus_pkg.sv
`default_nettype none

package dac_bus_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // region field in paddr[15:14], region 3 is unmapped
    localparam logic [1:0] REGION_CFG = 2'd0;
    localparam logic [1:0] REGION_VEC = 2'd1;
    localparam logic [1:0] REGION_COE = 2'd2;

    // config register index
    localparam logic [1:0] CFG_ROWS = 2'd0;
    localparam logic [1:0] CFG_COLS = 2'd1;
    localparam logic [1:0] CFG_DIV  = 2'd2;

    typedef struct packed {
        logic [1:0]  region;
        logic [11:0] rsvd;
        logic [1:0]  index;
    } cfg_addr_t;

    typedef struct packed {
        logic [1:0] region;
        logic [7:0] rsvd;
        logic [5:0] col;
    } vec_addr_t;

    typedef struct packed {
        logic [1:0] region;
        logic [4:0] rsvd;
        logic [2:0] row;
        logic [5:0] col;
    } coe_addr_t;

    typedef union packed {
        cfg_addr_t cfg;
        vec_addr_t vec;
        coe_addr_t coe;
    } apb_addr_u;

endpackage

`default_nettype wire

// File: logic/sample_ram.sv
`default_nettype none

module sample_ram #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 10
) (
    input  logic                     clk_250MHz,
    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdat,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdat
);

    logic [WIDTH-1:0] mem [DEPTH];

    // one cycle read latency
    always_ff @(posedge clk_250MHz) begin
        if (wen) begin
            mem[waddr] <= wdat;
        end
        rdat <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: logic/mac_unit.sv
`default_nettype none

module mac_unit
    import dac_cfg_pkg::*;
(
    input  logic                clk_250MHz,
    input  logic                rst,
    input  logic                mac_clear,
    input  logic                mac_acc,
    input  logic [SAMPLE_W-1:0] sample,
    input  logic [COE_W-1:0]    coe,
    output logic [ACC_W-1:0]    sum,
    output logic                sum_valid
);

    logic [SAMPLE_W+COE_W-1:0] product;
    logic                      acc_q;

    assign product = {{COE_W{1'b0}}, sample} * {{SAMPLE_W{1'b0}}, coe};

    always_ff @(posedge clk_250MHz) begin
        if (rst) begin
            acc_q <= 1'b0;
        end else begin
            acc_q <= mac_acc;
        end
    end

    // clear loads the first product of a row
    always_ff @(posedge clk_250MHz) begin
        if (mac_acc) begin
            sum <= mac_clear ? ACC_W'(product) : sum + ACC_W'(product);
        end
    end

    // row done once accumulation stops or the next row clears
    assign sum_valid = acc_q && (mac_clear || !mac_acc);

endmodule

`default_nettype wire

// File: logic/dac_divider.sv
`default_nettype none

module dac_divider
    import dac_cfg_pkg::*;
(
    input  logic             clk_250MHz,
    input  logic             rst,
    input  logic             div_start,
    input  logic [ACC_W-1:0] dividend,
    input  logic [ROW_W-1:0] div_row,
    input  logic [DIV_W-1:0] divisor,
    output logic             busy,
    output logic             dac_en,
    output dac_result_t      dac_out
);

    logic [ACC_W-1:0]         quo;
    logic [DIV_W-1:0]         rem;
    logic [DIV_W-1:0]         dvs;
    logic [ROW_W-1:0]         row;
    logic [$clog2(ACC_W)-1:0] step;
    logic [DIV_W:0]           rem_sh;
    logic [DIV_W+1:0]         trial;
    logic                     borrow;
    logic [ACC_W-1:0]         quo_nxt;
    logic                     last_step;

    // restoring step, msb of the dividend shifts into the remainder
    assign rem_sh    = {rem, quo[ACC_W-1]};
    assign trial     = {1'b0, rem_sh} - {2'b00, dvs};
    assign borrow    = trial[DIV_W+1];
    assign quo_nxt   = {quo[ACC_W-2:0], !borrow};
    assign last_step = busy && (int'(step) == ACC_W - 1);

    always_ff @(posedge clk_250MHz) begin
        if (rst) begin
            busy   <= 1'b0;
            dac_en <= 1'b0;
            step   <= '0;
        end else begin
            dac_en <= last_step;
            if (div_start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_250MHz) begin
        if (div_start) begin
            quo <= dividend;
            rem <= '0;
            dvs <= divisor;
            row <= div_row;
        end else if (busy) begin
            quo <= quo_nxt;
            rem <= borrow ? rem_sh[DIV_W-1:0] : trial[DIV_W-1:0];
        end
        // divisor 0 never borrows, all ones saturates too
        if (last_step) begin
            dac_out.row    <= row;
            dac_out.sample <= (quo_nxt > ACC_W'(DAC_MAX)) ? DAC_W'(DAC_MAX)
                                                          : quo_nxt[DAC_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/mvm_ctrl.sv
`default_nettype none

module mvm_ctrl
    import dac_cfg_pkg::*;
(
    input  logic                   clk_250MHz,
    input  logic                   rst,
    input  logic                   trg,
    input  logic [ROW_W:0]         num_rows,
    input  logic [COL_W:0]         num_cols,
    input  logic                   div_busy,
    output logic [COL_W-1:0]       vec_raddr,
    output logic [ROW_W+COL_W-1:0] coe_raddr,
    output logic                   mac_clear,
    output logic                   mac_acc,
    input  logic                   sum_valid,
    output logic                   div_start,
    output logic [ROW_W-1:0]       div_row,
    output engine_state_t          state
);

    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    // row tags following the RAM and MAC stages
    logic [ROW_W-1:0] row_rd;
    logic [ROW_W-1:0] row_sum;
    logic             all_sent;
    logic             issue;
    logic             col_last;
    logic             sum_last;
    logic             handoff;

    assign issue     = (state == accumulate);
    assign vec_raddr = col;
    assign coe_raddr = {row, col};

    // a count of 0 runs to the full limit
    assign col_last = ({1'b0, col} == num_cols - 1'b1) || (&col);
    assign sum_last = ({1'b0, row_sum} == num_rows - 1'b1) || (&row_sum);

    always_comb begin
        handoff = 1'b0;
        if (state == drain && !all_sent) begin
            handoff = sum_valid && !div_busy;
        end else if (state == divide_wait) begin
            handoff = !div_busy;
        end
    end

    assign div_start = handoff;
    assign div_row   = row_sum;

    always_ff @(posedge clk_250MHz) begin
        if (rst) begin
            state     <= idle;
            row       <= '0;
            col       <= '0;
            all_sent  <= 1'b0;
            mac_acc   <= 1'b0;
            mac_clear <= 1'b0;
        end else begin
            // MAC controls line up with the registered RAM data
            mac_acc   <= issue;
            mac_clear <= issue && (col == '0);
            case (state)
                idle: begin
                    if (trg) begin
                        state    <= accumulate;
                        row      <= '0;
                        col      <= '0;
                        all_sent <= 1'b0;
                    end
                end
                accumulate: begin
                    if (col_last) begin
                        col   <= '0;
                        row   <= row + 1'b1;
                        state <= drain;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                drain: begin
                    if (all_sent && !div_busy) begin
                        state <= idle;
                    end else if (!all_sent && sum_valid && div_busy) begin
                        state <= divide_wait;
                    end
                end
                default: ;
            endcase
            if (handoff) begin
                if (sum_last) begin
                    state    <= drain;
                    all_sent <= 1'b1;
                end else begin
                    state <= accumulate;
                end
            end
        end
    end

    always_ff @(posedge clk_250MHz) begin
        if (issue) begin
            row_rd <= row;
        end
        if (mac_acc) begin
            row_sum <= row_rd;
        end
    end

endmodule

`default_nettype wire

// File: logic/apb_loader.sv
`default_nettype none

module apb_loader
    import dac_cfg_pkg::*;
    import dac_bus_pkg::*;
(
    input  logic                   clk_250MHz,
    input  logic                   rst,
    input  apb_req_t               apb,
    input  logic                   engine_idle,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   vec_wen,
    output logic [COL_W-1:0]       vec_waddr,
    output logic [SAMPLE_W-1:0]    vec_wdat,
    output logic                   coe_wen,
    output logic [ROW_W+COL_W-1:0] coe_waddr,
    output logic [COE_W-1:0]       coe_wdat,
    output logic [ROW_W:0]         num_rows,
    output logic [COL_W:0]         num_cols,
    output logic [DIV_W-1:0]       divisor
);

    apb_addr_u  addr;
    logic [1:0] region;
    logic       bad_addr;
    logic       wr;

    assign addr     = apb.paddr;
    assign region   = addr.cfg.region;
    assign bad_addr = (region == 2'd3) || (region == REGION_CFG && addr.cfg.index == 2'd3);

    // access phase stretched until the engine is idle
    assign pready  = apb.psel && apb.penable && engine_idle;
    assign pslverr = pready && bad_addr;
    assign wr      = pready && apb.pwrite && !bad_addr;

    assign vec_wen   = wr && (region == REGION_VEC);
    assign vec_waddr = addr.vec.col;
    assign vec_wdat  = apb.pwdata[SAMPLE_W-1:0];

    // row-major coefficient layout
    assign coe_wen   = wr && (region == REGION_COE);
    assign coe_waddr = {addr.coe.row, addr.coe.col};
    assign coe_wdat  = apb.pwdata[COE_W-1:0];

    always_comb begin
        prdata = '0;
        if (region == REGION_CFG) begin
            case (addr.cfg.index)
                CFG_ROWS: prdata = 32'(num_rows);
                CFG_COLS: prdata = 32'(num_cols);
                CFG_DIV:  prdata = 32'(divisor);
                default:  prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk_250MHz) begin
        if (rst) begin
            num_rows <= {{ROW_W{1'b0}}, 1'b1};
            num_cols <= {{COL_W{1'b0}}, 1'b1};
            divisor  <= {{(DIV_W-1){1'b0}}, 1'b1};
        end else if (wr && region == REGION_CFG) begin
            case (addr.cfg.index)
                CFG_ROWS: num_rows <= apb.pwdata[ROW_W:0];
                CFG_COLS: num_cols <= apb.pwdata[COL_W:0];
                CFG_DIV:  divisor  <= apb.pwdata[DIV_W-1:0];
                default:  ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/matrix_dac_top.sv
`default_nettype none

module matrix_dac_top
    import dac_cfg_pkg::*;
    import dac_bus_pkg::*;
(
    input  logic          clk_250MHz,
    input  logic          rst,
    input  logic          trg,
    input  apb_req_t      apb,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr,
    output engine_state_t state,
    output logic          dac_en,
    output dac_result_t   dac_out
);

    logic                    engine_idle;
    logic                    vec_wen;
    logic [COL_W-1:0]        vec_waddr;
    logic [SAMPLE_W-1:0]     vec_wdat;
    logic                    coe_wen;
    logic [ROW_W+COL_W-1:0]  coe_waddr;
    logic [COE_W-1:0]        coe_wdat;
    logic [ROW_W:0]          num_rows;
    logic [COL_W:0]          num_cols;
    logic [DIV_W-1:0]        divisor;
    logic [COL_W-1:0]        vec_raddr;
    logic [ROW_W+COL_W-1:0]  coe_raddr;
    logic [SAMPLE_W-1:0]     vec_rdat;
    logic [COE_W-1:0]        coe_rdat;
    logic                    mac_clear;
    logic                    mac_acc;
    logic [ACC_W-1:0]        sum;
    logic                    sum_valid;
    logic                    div_start;
    logic [ROW_W-1:0]        div_row;
    logic                    div_busy;

    assign engine_idle = (state == idle);

    apb_loader loader_i (
        .clk_250MHz  (clk_250MHz),
        .rst         (rst),
        .apb         (apb),
        .engine_idle (engine_idle),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .vec_wen     (vec_wen),
        .vec_waddr   (vec_waddr),
        .vec_wdat    (vec_wdat),
        .coe_wen     (coe_wen),
        .coe_waddr   (coe_waddr),
        .coe_wdat    (coe_wdat),
        .num_rows    (num_rows),
        .num_cols    (num_cols),
        .divisor     (divisor)
    );

    sample_ram #(.DEPTH(MAX_COLS), .WIDTH(SAMPLE_W)) vec_ram_i (
        .clk_250MHz (clk_250MHz),
        .wen        (vec_wen),
        .waddr      (vec_waddr),
        .wdat       (vec_wdat),
        .raddr      (vec_raddr),
        .rdat       (vec_rdat)
    );

    sample_ram #(.DEPTH(MAX_ROWS * MAX_COLS), .WIDTH(COE_W)) coe_ram_i (
        .clk_250MHz (clk_250MHz),
        .wen        (coe_wen),
        .waddr      (coe_waddr),
        .wdat       (coe_wdat),
        .raddr      (coe_raddr),
        .rdat       (coe_rdat)
    );

    mvm_ctrl ctrl_i (
        .clk_250MHz (clk_250MHz),
        .rst        (rst),
        .trg        (trg),
        .num_rows   (num_rows),
        .num_cols   (num_cols),
        .div_busy   (div_busy),
        .vec_raddr  (vec_raddr),
        .coe_raddr  (coe_raddr),
        .mac_clear  (mac_clear),
        .mac_acc    (mac_acc),
        .sum_valid  (sum_valid),
        .div_start  (div_start),
        .div_row    (div_row),
        .state      (state)
    );

    mac_unit mac_i (
        .clk_250MHz (clk_250MHz),
        .rst        (rst),
        .mac_clear  (mac_clear),
        .mac_acc    (mac_acc),
        .sample     (vec_rdat),
        .coe        (coe_rdat),
        .sum        (sum),
        .sum_valid  (sum_valid)
    );

    dac_divider div_i (
        .clk_250MHz (clk_250MHz),
        .rst        (rst),
        .div_start  (div_start),
        .dividend   (sum),
        .div_row    (div_row),
        .divisor    (divisor),
        .busy       (div_busy),
        .dac_en     (dac_en),
        .dac_out    (dac_out)
    );

endmodule

`default_nettype wire

// File: include/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

`default_nettype none

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] seed);
    logic [31:0] x;
    x = seed;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// expected DAC sample for one row of the active shape
function automatic logic [dac_cfg_pkg::DAC_W-1:0] ref_sample(
    input logic [dac_cfg_pkg::SAMPLE_W-1:0] vec [dac_cfg_pkg::MAX_COLS],
    input logic [dac_cfg_pkg::COE_W-1:0]
        coe [dac_cfg_pkg::MAX_ROWS][dac_cfg_pkg::MAX_COLS],
    input int row,
    input int cols,
    input int divisor
);
    longint sum;
    longint quo;
    sum = 0;
    for (int c = 0; c < cols; c++) begin
        sum += longint'(vec[c]) * longint'(coe[row][c]);
    end
    // divide by zero saturates like the hardware
    if (divisor == 0) begin
        return dac_cfg_pkg::DAC_W'(dac_cfg_pkg::DAC_MAX);
    end
    quo = sum / longint'(divisor);
    if (quo > dac_cfg_pkg::DAC_MAX) begin
        return dac_cfg_pkg::DAC_W'(dac_cfg_pkg::DAC_MAX);
    end
    return dac_cfg_pkg::DAC_W'(quo);
endfunction

`default_nettype wire

`endif

// File: tests/tb_matrix_dac.sv
`default_nettype none

module tb_matrix_dac
    import dac_cfg_pkg::*;
    import dac_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    `include "tb_model.svh"

    localparam int CLK_PERIOD = 100;
    // rows * (cols + 30) summed over every run of the tests
    localparam int RUN_CYCLES = 3 * 8 * (64 + 30) + 1 * (1 + 30) + 4 * 3 * (5 + 30);
    // about 1200 transfers, at most 4 cycles each outside a stall
    localparam int APB_CYCLES = 4 * 1300;
    localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES + APB_CYCLES + 5;

    logic          clk;
    logic          rst;
    logic          trg;
    apb_req_t      apb;
    logic [31:0]   prdata;
    logic          pready;
    logic          pslverr;
    engine_state_t state;
    logic          dac_en;
    dac_result_t   dac_out;

    // shadow of what the DUT memories and config hold
    logic [SAMPLE_W-1:0] vec_m [MAX_COLS];
    logic [COE_W-1:0]    coe_m [MAX_ROWS][MAX_COLS];
    int                  cfg_rows;
    int                  cfg_cols;
    int                  cfg_div;
    logic [31:0]         rnd;
    dac_result_t         exp_q [$];

    logic [31:0]   last_rdata;
    logic          last_err;
    engine_state_t last_state;
    int            last_waits;

    int checks;
    int value_errs;
    int other_errs;
    int cmp_checks;
    int cmp_errs;
    int cmp_other;

    matrix_dac_top dut_i (
        .clk_250MHz (clk),
        .rst        (rst),
        .trg        (trg),
        .apb        (apb),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .state      (state),
        .dac_en     (dac_en),
        .dac_out    (dac_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act == exp) else begin
            value_errs++;
            $display("[ERROR] %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    // one APB transfer, holds the access phase until pready
    task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite  <= wr;
        apb.paddr   <= addr;
        apb.pwdata  <= wdata;
        @(posedge clk);
        apb.penable <= 1'b1;
        last_waits = 0;
        @(negedge clk);
        while (!pready) begin
            last_waits++;
            @(negedge clk);
        end
        last_rdata = prdata;
        last_err   = pslverr;
        last_state = state;
        @(posedge clk);
        apb.psel    <= 1'b0;
        apb.penable <= 1'b0;
    endtask

    task automatic write_vec(input int c, input logic [SAMPLE_W-1:0] v);
        apb_xfer(1'b1, {REGION_VEC, 8'h00, 6'(c)}, 32'(v));
        check_value("pslverr", 32'h0, 32'(last_err));
        vec_m[c] = v;
    endtask

    task automatic write_coe(input int r, input int c, input logic [COE_W-1:0] v);
        apb_xfer(1'b1, {REGION_COE, 5'h00, 3'(r), 6'(c)}, 32'(v));
        check_value("pslverr", 32'h0, 32'(last_err));
        coe_m[r][c] = v;
    endtask

    task automatic write_cfg(input int idx, input int v);
        apb_xfer(1'b1, {REGION_CFG, 12'h000, 2'(idx)}, 32'(v));
        check_value("pslverr", 32'h0, 32'(last_err));
        case (idx)
            0: cfg_rows = v;
            1: cfg_cols = v;
            default: cfg_div = v;
        endcase
    endtask

    task automatic read_cfg(input int idx, input int exp);
        apb_xfer(1'b0, {REGION_CFG, 12'h000, 2'(idx)}, 32'h0);
        check_value("prdata", 32'(exp), last_rdata);
    endtask

    task automatic set_shape(input int rows, input int cols, input int div);
        write_cfg(0, rows);
        write_cfg(1, cols);
        write_cfg(2, div);
    endtask

    // narrow values keep the row sums below full scale
    task automatic load_random(input int rows, input int cols, input int bits);
        logic [31:0] mask;
        mask = (32'd1 << bits) - 32'd1;
        for (int c = 0; c < cols; c++) begin
            rnd = xorshift32(rnd);
            write_vec(c, SAMPLE_W'(rnd & mask));
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                rnd = xorshift32(rnd);
                write_coe(r, c, COE_W'(rnd & mask));
            end
        end
    endtask

    task automatic load_const(input logic [SAMPLE_W-1:0] v);
        for (int c = 0; c < MAX_COLS; c++) begin
            write_vec(c, v);
        end
        for (int r = 0; r < MAX_ROWS; r++) begin
            for (int c = 0; c < MAX_COLS; c++) begin
                write_coe(r, c, v);
            end
        end
    endtask

    task automatic start_run();
        dac_result_t e;
        for (int r = 0; r < cfg_rows; r++) begin
            e.row    = ROW_W'(r);
            e.sample = ref_sample(vec_m, coe_m, r, cfg_cols, cfg_div);
            exp_q.push_back(e);
        end
        @(posedge clk);
        trg <= 1'b1;
        @(posedge clk);
        trg <= 1'b0;
        @(negedge clk);
        checks++;
        assert (state == accumulate) else begin
            other_errs++;
            $display("engine did not enter accumulate one cycle after the trigger");
        end
    endtask

    task automatic wait_done();
        while (state != idle) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        checks++;
        assert (exp_q.size() == 0) else begin
            other_errs++;
            $display("run ended with %0d results missing", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic run_and_check();
        start_run();
        wait_done();
    endtask

    // every DAC strobe is matched against the expected queue
    always @(negedge clk) begin
        dac_result_t exp_r;
        if (!rst && dac_en) begin
            cmp_checks++;
            if (exp_q.size() == 0) begin
                cmp_other++;
                $display("DAC result for row %0d arrived with no result expected", dac_out.row);
            end else begin
                exp_r = exp_q.pop_front();
                assert (dac_out.row == exp_r.row) else begin
                    cmp_errs++;
                    $display("[ERROR] dac_out.row expected 0x%h actual 0x%h",
                             exp_r.row, dac_out.row);
                end
                assert (dac_out.sample == exp_r.sample) else begin
                    cmp_errs++;
                    $display("[ERROR] dac_out.sample expected 0x%h actual 0x%h",
                             exp_r.sample, dac_out.sample);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the tests finished", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        trg = 1'b0;
        apb = '0;
        rnd = 32'h12c3c2dd;
        cfg_rows = 1;
        cfg_cols = 1;
        cfg_div = 1;
        checks = 0;
        value_errs = 0;
        other_errs = 0;
        cmp_checks = 0;
        cmp_errs = 0;
        cmp_other = 0;
        for (int c = 0; c < MAX_COLS; c++) begin
            vec_m[c] = '0;
            for (int r = 0; r < MAX_ROWS; r++) begin
                coe_m[r][c] = '0;
            end
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // reset values
        @(negedge clk);
        check_value("dac_en", 32'h0, 32'(dac_en));
        check_value("pready", 32'h0, 32'(pready));
        check_value("state", 32'(idle), 32'(state));
        read_cfg(0, 1);
        read_cfg(1, 1);
        read_cfg(2, 1);

        // full random matrix
        load_random(MAX_ROWS, MAX_COLS, 4);
        set_shape(8, 64, 17);
        run_and_check();

        // saturation, then divide by zero
        load_const(10'h3ff);
        write_cfg(2, 1);
        run_and_check();
        write_cfg(2, 0);
        run_and_check();

        // small shapes, the rest of memory keeps the saturation pattern
        load_random(1, 1, 5);
        set_shape(1, 1, 3);
        run_and_check();
        load_random(3, 5, 5);
        set_shape(3, 5, 5);
        run_and_check();

        // write during a run is stalled until idle
        start_run();
        write_cfg(2, 9);
        checks++;
        assert (last_state == idle && last_waits > 0) else begin
            other_errs++;
            $display("config write completed while the engine was still busy");
        end
        wait_done();
        run_and_check();

        // unmapped region and config index 3
        apb_xfer(1'b1, 16'hc002, 32'h0000_0001);
        check_value("pslverr", 32'h1, 32'(last_err));
        apb_xfer(1'b1, 16'h0003, 32'h0000_0007);
        check_value("pslverr", 32'h1, 32'(last_err));
        run_and_check();

        repeat (5) @(negedge clk);
        $display("checks: %0d, value errors: %0d, other errors: %0d",
                 checks + cmp_checks, value_errs + cmp_errs, other_errs + cmp_other);
        if (value_errs + cmp_errs + other_errs + cmp_other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
logic/dac_cfg_pkg.sv
logic/dac_bus_pkg.sv
logic/sample_ram.sv
logic/mac_unit.sv
logic/dac_divider.sv
logic/mvm_ctrl.sv
logic/apb_loader.sv
logic/matrix_dac_top.sv
tests/tb_matrix_dac.sv

// File: Makefile
LOG = sim.log

sim:
	verilator --binary --assert --top-module tb_matrix_dac -f src.f --Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
